/* verilog/cart_map_pkg.sv */
package cart_map_pkg;

   ///////////////////////////////
   // memory map widths
   ///////////////////////////////

   // memory address as loaded by the MCU, three bytes
   localparam int unsigned ADDR_W = 24;

   // ROM and save-RAM masks, same three-byte layout as the address
   localparam int unsigned MASK_W = 24;

   // mapper number, carried in the low nibble of the command
   localparam int unsigned MAPPER_W = 4;

   ///////////////////////////////
   // on-chip memory
   ///////////////////////////////

   // address bits decoded by the byte memory, 1 KiB by default
   localparam int unsigned MEM_AW_DEFAULT = 10;

endpackage

/* verilog/mcu_cmd_pkg.sv */
package mcu_cmd_pkg;

   ///////////////////////////////
   // upper-nibble opcodes
   ///////////////////////////////

   localparam logic [3:0] OP_SET_ADDR  = 4'h0;
   localparam logic [3:0] OP_ROM_MASK  = 4'h1;
   localparam logic [3:0] OP_SAVE_MASK = 4'h2;
   localparam logic [3:0] OP_MAPPER    = 4'h3;
   localparam logic [3:0] OP_READ      = 4'h8;
   localparam logic [3:0] OP_WRITE     = 4'h9;

   ///////////////////////////////
   // full-byte commands
   ///////////////////////////////

   // playback control
   localparam logic [7:0] CMD_PAUSE  = 8'hE1;
   localparam logic [7:0] CMD_RESUME = 8'hE2;
   // identity and loopback
   localparam logic [7:0] CMD_ID     = 8'hF0;
   localparam logic [7:0] CMD_ECHO   = 8'hFF;

   // returned for CMD_ID
   localparam logic [7:0] ID_BYTE = 8'hA5;

   // spi framing counters
   localparam int unsigned BYTE_CNT_W = 16;
   localparam int unsigned BIT_CNT_W  = 3;

   // command byte, read whole or as opcode and argument
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [3:0] op;
         logic [3:0] arg;
      } nib;
   } cmd_byte_u;

endpackage

/* verilog/spi_slave.sv */
`timescale 1ns/10ps

module spi_slave (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                sck,
   input  logic                                cs_n,
   input  logic                                mosi,
   output logic                                miso,
   output logic                                cmd_ready,
   output logic                                param_ready,
   output logic [7:0]                          cmd_data,
   output logic [7:0]                          param_data,
   output logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]  byte_cnt,
   output logic [mcu_cmd_pkg::BIT_CNT_W-1:0]   bit_cnt,
   input  logic [7:0]                          reply_data
);

   logic [1:0] sck_sync;
   logic [1:0] cs_sync;
   logic [1:0] mosi_sync;
   logic       sck_d;
   logic       cs_active;
   logic       sck_rise;
   logic       sck_fall;
   logic       byte_done;
   logic [7:0] rx_shift;
   logic [7:0] rx_byte;
   logic [7:0] tx_shift;

   ///////////////////////////////
   // input synchronizers
   ///////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sck_sync  <= 2'b00;
         cs_sync   <= 2'b11;
         mosi_sync <= 2'b00;
         sck_d     <= 1'b0;
      end else begin
         sck_sync  <= {sck_sync[0], sck};
         cs_sync   <= {cs_sync[0], cs_n};
         mosi_sync <= {mosi_sync[0], mosi};
         sck_d     <= sck_sync[1];
      end
   end

   assign cs_active = ~cs_sync[1];
   assign sck_rise  = cs_active & sck_sync[1] & ~sck_d;
   assign sck_fall  = cs_active & ~sck_sync[1] & sck_d;
   // eighth rising edge of a byte
   assign byte_done = sck_rise & (bit_cnt == '1);
   assign rx_byte   = {rx_shift[6:0], mosi_sync[1]};

   ///////////////////////////////
   // receive framing
   ///////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         cmd_data    <= 8'h00;
      end else if (!cs_active) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
      end else begin
         cmd_ready   <= byte_done & (byte_cnt == '0);
         param_ready <= byte_done & (byte_cnt != '0);
         if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         if (byte_done) begin
            byte_cnt <= byte_cnt + 1'b1;
            // first byte of the transfer is the command
            if (byte_cnt == '0) begin
               cmd_data <= rx_byte;
            end
         end
      end
   end

   // mode 0, sampled on the rising edge
   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= rx_byte;
      end
      if (byte_done && byte_cnt != '0) begin
         param_data <= rx_byte;
      end
   end

   ///////////////////////////////
   // transmit
   ///////////////////////////////

   // reply byte enters on the falling edge after the eighth rise,
   // the decoder has settled it by then
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_shift <= 8'h00;
      end else if (!cs_active) begin
         tx_shift <= 8'h00;
      end else if (sck_fall) begin
         if (bit_cnt == '0) begin
            tx_shift <= reply_data;
         end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
      end
   end

   // MSB first, held low while deselected
   assign miso = ~cs_n & tx_shift[7];

endmodule

/* verilog/mcu_cmd.sv */
`timescale 1ns/10ps

module mcu_cmd (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                cmd_ready,
   input  logic                                param_ready,
   input  logic [7:0]                          cmd_data,
   input  logic [7:0]                          param_data,
   input  logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]  byte_cnt,
   input  logic [mcu_cmd_pkg::BIT_CNT_W-1:0]   bit_cnt,
   output logic [7:0]                          reply_data,
   output logic [cart_map_pkg::MAPPER_W-1:0]   mapper,
   output logic [cart_map_pkg::MASK_W-1:0]     rom_mask,
   output logic [cart_map_pkg::MASK_W-1:0]     saveram_mask,
   output logic [cart_map_pkg::ADDR_W-1:0]     mem_addr,
   output logic                                read_n,
   output logic                                write_n,
   output logic [7:0]                          wdata,
   input  logic [7:0]                          rdata,
   output logic                                dac_play
);

   mcu_cmd_pkg::cmd_byte_u                cmd;
   logic [mcu_cmd_pkg::BIT_CNT_W-1:0]     bit_cnt_d;
   logic                                  is_read;
   logic                                  is_write;
   logic                                  write_win;
   logic                                  read_win;
   logic                                  step;

   // three-byte big-endian field, the first byte clears the rest
   function automatic logic [23:0] load_be24(
      input logic [23:0]                         cur,
      input logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]  idx,
      input logic [7:0]                          b
   );
      logic [23:0] nxt;
      nxt = cur;
      case (idx)
         2: nxt = {b, 16'h0000};
         3: nxt[15:8] = b;
         4: nxt[7:0] = b;
         default: nxt = cur;
      endcase
      return nxt;
   endfunction

   assign cmd      = cmd_data;
   assign is_read  = (cmd.nib.op == mcu_cmd_pkg::OP_READ);
   assign is_write = (cmd.nib.op == mcu_cmd_pkg::OP_WRITE);

   ///////////////////////////////
   // settings and address
   ///////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mapper       <= '0;
         rom_mask     <= '0;
         saveram_mask <= '0;
         mem_addr     <= '0;
         dac_play     <= 1'b0;
      end else begin
         if (cmd_ready) begin
            if (cmd.raw == mcu_cmd_pkg::CMD_PAUSE) begin
               dac_play <= 1'b0;
            end else if (cmd.raw == mcu_cmd_pkg::CMD_RESUME) begin
               dac_play <= 1'b1;
            end else if (cmd.nib.op == mcu_cmd_pkg::OP_MAPPER) begin
               mapper <= cmd.nib.arg;
            end
         end
         if (param_ready) begin
            case (cmd.nib.op)
               mcu_cmd_pkg::OP_SET_ADDR:
                  mem_addr <= load_be24(mem_addr, byte_cnt, param_data);
               mcu_cmd_pkg::OP_ROM_MASK:
                  rom_mask <= load_be24(rom_mask, byte_cnt, param_data);
               mcu_cmd_pkg::OP_SAVE_MASK:
                  saveram_mask <= load_be24(saveram_mask, byte_cnt, param_data);
               default: ;
            endcase
         end
         // only for read and write bursts, never with an address load
         if (step) begin
            mem_addr <= mem_addr + 1'b1;
         end
      end
   end

   // write data for the next byte's strobe
   always_ff @(posedge clk) begin
      if (param_ready && is_write) begin
         wdata <= param_data;
      end
   end

   ///////////////////////////////
   // strobes
   ///////////////////////////////

   // a parameter is written during the byte that follows it,
   // so a write burst closes with one extra byte
   assign write_win = (bit_cnt_d >= 3'd1) && (bit_cnt_d <= 3'd3) && is_write &&
                      (byte_cnt > 1);
   assign read_win  = (bit_cnt_d >= 3'd5) && is_read && (byte_cnt > 0);

   // next byte's bit 0 begins, byte_cnt has already moved on
   assign step = (bit_cnt == '0) && (bit_cnt_d == '1) &&
                 ((is_read && byte_cnt > 1) || (is_write && byte_cnt > 2));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt_d <= '0;
         read_n    <= 1'b1;
         write_n   <= 1'b1;
      end else begin
         bit_cnt_d <= bit_cnt;
         read_n    <= ~read_win;
         write_n   <= ~write_win;
      end
   end

   ///////////////////////////////
   // reply select
   ///////////////////////////////

   // the delayed count stays at 7 one clk past the byte end,
   // so the last update sees the new command and parameter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reply_data <= 8'h00;
      end else if (bit_cnt_d == '1) begin
         if (cmd.raw == mcu_cmd_pkg::CMD_ID) begin
            reply_data <= mcu_cmd_pkg::ID_BYTE;
         end else if (cmd.raw == mcu_cmd_pkg::CMD_ECHO) begin
            reply_data <= param_data;
         end else if (is_read) begin
            reply_data <= rdata;
         end else begin
            reply_data <= cmd.raw;
         end
      end
   end

endmodule

/* verilog/sram_port.sv */
`timescale 1ns/10ps

module sram_port #(
   parameter int MEM_AW = cart_map_pkg::MEM_AW_DEFAULT
) (
   input  logic                             clk,
   input  logic [cart_map_pkg::ADDR_W-1:0]  addr,
   input  logic                             read_n,
   input  logic                             write_n,
   input  logic [7:0]                       wdata,
   output logic [7:0]                       rdata
);

   logic [7:0]        mem [2**MEM_AW];
   logic [MEM_AW-1:0] word_addr;

   // upper address bits alias onto the small array
   assign word_addr = addr[MEM_AW-1:0];

   ///////////////////////////////
   // byte array
   ///////////////////////////////

   always_ff @(posedge clk) begin
      // repeated writes over the strobe land the same byte
      if (!write_n) begin
         mem[word_addr] <= wdata;
      end
      // read data one clk after the strobe
      if (!read_n) begin
         rdata <= mem[word_addr];
      end
   end

endmodule

/* verilog/cart_ctrl_top.sv */
`timescale 1ns/10ps

module cart_ctrl_top #(
   parameter int MEM_AW = cart_map_pkg::MEM_AW_DEFAULT
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               sck,
   input  logic                               cs_n,
   input  logic                               mosi,
   output logic                               miso,
   output logic [cart_map_pkg::MAPPER_W-1:0]  mapper,
   output logic [cart_map_pkg::MASK_W-1:0]    rom_mask,
   output logic [cart_map_pkg::MASK_W-1:0]    saveram_mask,
   output logic [cart_map_pkg::ADDR_W-1:0]    mem_addr,
   output logic                               dac_play
);

   // spi framing to decoder
   logic                               cmd_ready;
   logic                               param_ready;
   logic [7:0]                         cmd_data;
   logic [7:0]                         param_data;
   logic [mcu_cmd_pkg::BYTE_CNT_W-1:0] byte_cnt;
   logic [mcu_cmd_pkg::BIT_CNT_W-1:0]  bit_cnt;
   logic [7:0]                         reply_data;

   // decoder to memory
   logic                               read_n;
   logic                               write_n;
   logic [7:0]                         wdata;
   logic [7:0]                         rdata;

   spi_slave u_spi_slave (
      .clk         (clk),
      .rst_n       (rst_n),
      .sck         (sck),
      .cs_n        (cs_n),
      .mosi        (mosi),
      .miso        (miso),
      .cmd_ready   (cmd_ready),
      .param_ready (param_ready),
      .cmd_data    (cmd_data),
      .param_data  (param_data),
      .byte_cnt    (byte_cnt),
      .bit_cnt     (bit_cnt),
      .reply_data  (reply_data)
   );

   mcu_cmd u_mcu_cmd (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_ready    (cmd_ready),
      .param_ready  (param_ready),
      .cmd_data     (cmd_data),
      .param_data   (param_data),
      .byte_cnt     (byte_cnt),
      .bit_cnt      (bit_cnt),
      .reply_data   (reply_data),
      .mapper       (mapper),
      .rom_mask     (rom_mask),
      .saveram_mask (saveram_mask),
      .mem_addr     (mem_addr),
      .read_n       (read_n),
      .write_n      (write_n),
      .wdata        (wdata),
      .rdata        (rdata),
      .dac_play     (dac_play)
   );

   sram_port #(
      .MEM_AW (MEM_AW)
   ) u_sram_port (
      .clk     (clk),
      .addr    (mem_addr),
      .read_n  (read_n),
      .write_n (write_n),
      .wdata   (wdata),
      .rdata   (rdata)
   );

endmodule

/* test/cart_ctrl_checker.sv */
`timescale 1ns/10ps

module cart_ctrl_checker (
   input  logic clk,
   input  logic rst_n,
   input  logic cmd_ready,
   input  logic param_ready,
   input  logic read_n,
   input  logic write_n
);

   // failed assertions so far, watched by the testbench
   int unsigned assert_fails = 0;

   ///////////////////////////////
   // memory strobes
   ///////////////////////////////

   // memory is never read and written in one cycle
   strobe_excl: assert property (@(posedge clk) disable iff (!rst_n) read_n || write_n)
      else begin
         $error("read_n and write_n are low together");
         assert_fails++;
      end

   // both strobes idle while reset is held
   reset_idle: assert property (@(posedge clk) !rst_n ##1 !rst_n |-> (read_n && write_n))
      else begin
         $error("memory strobe active during reset");
         assert_fails++;
      end

   ///////////////////////////////
   // spi framing
   ///////////////////////////////

   ready_excl: assert property (@(posedge clk) disable iff (!rst_n) !(cmd_ready && param_ready))
      else begin
         $error("cmd_ready and param_ready are high together");
         assert_fails++;
      end

endmodule

bind mcu_cmd cart_ctrl_checker u_checker (
   .clk         (clk),
   .rst_n       (rst_n),
   .cmd_ready   (cmd_ready),
   .param_ready (param_ready),
   .read_n      (read_n),
   .write_n     (write_n)
);

/* test/tb_cart_ctrl.sv */
`timescale 1ns/10ps

module tb_cart_ctrl;

   localparam int N_TESTS = 12;
   localparam int MAX_LEN = 8;
   // at most 9 bytes of 64 clk per entry plus reset and gaps
   localparam int TIMEOUT_CYC = N_TESTS * 9 * 64 + 1000;

   logic                                  clk;
   logic                                  rst_n;
   logic                                  sck;
   logic                                  cs_n;
   logic                                  mosi;
   logic                                  miso;
   logic [cart_map_pkg::MAPPER_W-1:0]     mapper;
   logic [cart_map_pkg::MASK_W-1:0]       rom_mask;
   logic [cart_map_pkg::MASK_W-1:0]       saveram_mask;
   logic [cart_map_pkg::ADDR_W-1:0]       mem_addr;
   logic                                  dac_play;

   // stimulus table with byte 1 of a transfer in the top byte
   string                                 t_name [N_TESTS];
   int                                    t_len [N_TESTS];
   logic [MAX_LEN*8-1:0]                  t_tx [N_TESTS];
   logic [MAX_LEN*8-1:0]                  t_rx [N_TESTS];
   logic [MAX_LEN-1:0]                    t_chk [N_TESTS];
   logic [cart_map_pkg::MAPPER_W-1:0]     t_mapper [N_TESTS];
   logic [cart_map_pkg::MASK_W-1:0]       t_rom [N_TESTS];
   logic [cart_map_pkg::MASK_W-1:0]       t_save [N_TESTS];
   logic [cart_map_pkg::ADDR_W-1:0]       t_addr [N_TESTS];
   logic                                  t_play [N_TESTS];
   int                                    n_tests;

   // expected settings while the table is built
   logic [cart_map_pkg::MAPPER_W-1:0]     exp_mapper;
   logic [cart_map_pkg::MASK_W-1:0]       exp_rom;
   logic [cart_map_pkg::MASK_W-1:0]       exp_save;
   logic [cart_map_pkg::ADDR_W-1:0]       exp_addr;
   logic                                  exp_play;

   int                                    seed;
   logic [7:0]                            wr_data [4];
   int                                    cyc = 0;

   cart_ctrl_top #(
      .MEM_AW (cart_map_pkg::MEM_AW_DEFAULT)
   ) u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .sck          (sck),
      .cs_n         (cs_n),
      .mosi         (mosi),
      .miso         (miso),
      .mapper       (mapper),
      .rom_mask     (rom_mask),
      .saveram_mask (saveram_mask),
      .mem_addr     (mem_addr),
      .dac_play     (dac_play)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         fail_stop($sformatf("timeout, the tests did not finish within %0d clk", TIMEOUT_CYC));
      end else if (u_dut.u_mcu_cmd.u_checker.assert_fails != 0) begin
         fail_stop("an assertion in the decoder checker failed");
      end
   end

   ///////////////////////////////
   // error reporting and compares
   ///////////////////////////////

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         fail_stop($sformatf("[FAIL] %s: expected %02h, actual %02h", name, exp, act));
      end
   endtask

   task automatic check_mask(input string name, input logic [cart_map_pkg::MASK_W-1:0] exp,
                             input logic [cart_map_pkg::MASK_W-1:0] act);
      if (act !== exp) begin
         fail_stop($sformatf("[FAIL] %s: expected %06h, actual %06h", name, exp, act));
      end
   endtask

   task automatic check_addr(input string name, input logic [cart_map_pkg::ADDR_W-1:0] exp,
                             input logic [cart_map_pkg::ADDR_W-1:0] act);
      if (act !== exp) begin
         fail_stop($sformatf("[FAIL] %s: expected %06h, actual %06h", name, exp, act));
      end
   endtask

   task automatic check_mapper(input string name, input logic [cart_map_pkg::MAPPER_W-1:0] exp,
                               input logic [cart_map_pkg::MAPPER_W-1:0] act);
      if (act !== exp) begin
         fail_stop($sformatf("[FAIL] %s: expected %0h, actual %0h", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   ///////////////////////////////
   // table
   ///////////////////////////////

   task automatic add_test(input string name, input int len, input logic [MAX_LEN*8-1:0] tx,
                           input logic [MAX_LEN*8-1:0] rx, input logic [MAX_LEN-1:0] chk);
      t_name[n_tests]   = name;
      t_len[n_tests]    = len;
      t_tx[n_tests]     = tx;
      t_rx[n_tests]     = rx;
      t_chk[n_tests]    = chk;
      t_mapper[n_tests] = exp_mapper;
      t_rom[n_tests]    = exp_rom;
      t_save[n_tests]   = exp_save;
      t_addr[n_tests]   = exp_addr;
      t_play[n_tests]   = exp_play;
      n_tests++;
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      n_tests    = 0;
      exp_mapper = '0;
      exp_rom    = '0;
      exp_save   = '0;
      exp_addr   = '0;
      exp_play   = 1'b0;
      seed       = 56;
      for (int i = 0; i < 4; i++) begin
         rnd        = $random(seed);
         wr_data[i] = rnd[7:0];
      end
      // byte 1 always returns zero
      // byte 2 of echo and read is stale
      add_test("id", 3, {8'hF0, 56'h0}, {8'h00, 8'hA5, 8'hA5, 40'h0}, 8'b1110_0000);
      add_test("echo", 5, {8'hFF, 8'h11, 8'h22, 8'h33, 8'h44, 24'h0},
               {8'h00, 8'h00, 8'h11, 8'h22, 8'h33, 24'h0}, 8'b1011_1000);
      add_test("cmd_echo", 2, {8'h5A, 56'h0}, {8'h00, 8'h5A, 48'h0}, 8'b1100_0000);
      exp_mapper = 4'h7;
      add_test("mapper", 2, {8'h37, 56'h0}, {8'h00, 8'h37, 48'h0}, 8'b1100_0000);
      exp_rom = 24'hABCDEF;
      add_test("rom_mask", 4, {8'h10, 24'hABCDEF, 32'h0}, {8'h00, 24'h101010, 32'h0},
               8'b1111_0000);
      exp_save = 24'h012345;
      add_test("save_mask", 4, {8'h20, 24'h012345, 32'h0}, {8'h00, 24'h202020, 32'h0},
               8'b1111_0000);
      exp_addr = 24'h000123;
      add_test("set_addr", 4, {8'h00, 24'h000123, 32'h0}, 64'h0, 8'b1111_0000);
      // one closing byte lets the last data byte be written
      exp_addr = exp_addr + 4;
      add_test("write", 6, {8'h90, wr_data[0], wr_data[1], wr_data[2], wr_data[3], 8'h00, 16'h0},
               {8'h00, 40'h9090909090, 16'h0}, 8'b1111_1100);
      exp_addr = 24'h000123;
      add_test("set_addr_again", 4, {8'h00, 24'h000123, 32'h0}, 64'h0, 8'b1111_0000);
      // data trails by one byte
      // five dummy bytes give four checked reads and five steps
      exp_addr = exp_addr + 5;
      add_test("read", 6, {8'h80, 56'h0},
               {8'h00, 8'h00, wr_data[0], wr_data[1], wr_data[2], wr_data[3], 16'h0},
               8'b1011_1100);
      exp_play = 1'b1;
      add_test("resume", 2, {8'hE2, 56'h0}, {8'h00, 8'hE2, 48'h0}, 8'b1100_0000);
      exp_play = 1'b0;
      add_test("pause", 2, {8'hE1, 56'h0}, {8'h00, 8'hE1, 48'h0}, 8'b1100_0000);
   endtask

   ///////////////////////////////
   // spi master
   ///////////////////////////////

   // mode 0 with 4 clk low then 4 clk high per bit
   // miso sampled just before the rise
   task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
      for (int i = 7; i >= 0; i--) begin
         @(posedge clk);
         sck  <= 1'b0;
         mosi <= tx[i];
         repeat (3) @(posedge clk);
         @(negedge clk);
         rx[i] = miso;
         @(posedge clk);
         sck <= 1'b1;
         repeat (3) @(posedge clk);
      end
   endtask

   task automatic run_test(input int idx);
      logic [7:0] rx;
      string      name;
      name = t_name[idx];
      @(posedge clk);
      cs_n <= 1'b0;
      repeat (4) @(posedge clk);
      for (int k = 0; k < t_len[idx]; k++) begin
         spi_byte(t_tx[idx][(MAX_LEN-1-k)*8 +: 8], rx);
         if (t_chk[idx][MAX_LEN-1-k]) begin
            check_byte($sformatf("%s byte %0d", name, k + 1),
                       t_rx[idx][(MAX_LEN-1-k)*8 +: 8], rx);
         end
      end
      @(posedge clk);
      sck <= 1'b0;
      repeat (6) @(posedge clk);
      cs_n <= 1'b1;
      repeat (8) @(posedge clk);
      check_mapper({name, " mapper"}, t_mapper[idx], mapper);
      check_mask({name, " rom_mask"}, t_rom[idx], rom_mask);
      check_mask({name, " saveram_mask"}, t_save[idx], saveram_mask);
      check_addr({name, " mem_addr"}, t_addr[idx], mem_addr);
      check_flag({name, " dac_play"}, t_play[idx], dac_play);
   endtask

   initial begin
      rst_n = 1'b0;
      sck   = 1'b0;
      cs_n  = 1'b1;
      mosi  = 1'b0;
      build_table();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_mapper("reset mapper", '0, mapper);
      check_mask("reset rom_mask", '0, rom_mask);
      check_mask("reset saveram_mask", '0, saveram_mask);
      check_addr("reset mem_addr", '0, mem_addr);
      check_flag("reset dac_play", 1'b0, dac_play);
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      if (u_dut.u_mcu_cmd.u_checker.assert_fails == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         fail_stop($sformatf("%0d assertion failures in the decoder checker",
                             u_dut.u_mcu_cmd.u_checker.assert_fails));
      end
   end

endmodule

/* flist.f */
verilog/cart_map_pkg.sv
verilog/mcu_cmd_pkg.sv
verilog/spi_slave.sv
verilog/mcu_cmd.sv
verilog/sram_port.sv
verilog/cart_ctrl_top.sv
test/cart_ctrl_checker.sv
test/tb_cart_ctrl.sv
